//--- common/lbp_pkg.sv
// Local-history branch predictor definitions
// Widths, vector typedefs, request/update/train structs,
// counter encoding and the pattern table index fold

package lbp_pkg;

    // --------------------------------------------------
    // Widths and table sizes
    // History bits, kept a multiple of 8 for byte writes
    localparam int LH_LENGTH                 = 8;
    // 2-byte slots in a 16-byte fetch block
    localparam int LHT_ENTRIES_PER_BLOCK     = 8;
    localparam int LOG_LHT_ENTRIES_PER_BLOCK = 3;
    localparam int LHT_SETS                  = 64;
    localparam int LHT_INDEX_WIDTH           = 6;
    localparam int ASID_WIDTH                = 9;
    localparam int LPT_ENTRIES               = 256;
    localparam int LPT_INDEX_WIDTH           = 8;

    // --------------------------------------------------
    // Plain vector types
    typedef logic [31:0]                                   pc_t;
    typedef logic [ASID_WIDTH-1:0]                         asid_t;
    typedef logic [LH_LENGTH-1:0]                          lh_t;
    typedef logic [LHT_INDEX_WIDTH-1:0]                    lht_index_t;
    typedef logic [LPT_INDEX_WIDTH-1:0]                    lpt_index_t;
    typedef logic [LOG_LHT_ENTRIES_PER_BLOCK-1:0]          instr_sel_t;
    // Slot 0 history in the low byte
    typedef logic [LHT_ENTRIES_PER_BLOCK*LH_LENGTH-1:0]    lh_block_t;
    typedef logic [LHT_ENTRIES_PER_BLOCK-1:0]              pred_block_t;

    // --------------------------------------------------
    // Strobed transactions
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        asid_t asid;
    } fetch_req_t;

    // Resolved conditional branch with its prediction-time history
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        asid_t asid;
        logic  taken;
        lh_t   old_lh;
    } resolve_t;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        asid_t asid;
        lh_t   new_lh;
    } lh_update_t;

    typedef struct packed {
        logic       valid;
        lpt_index_t index;
        logic       taken;
    } lpt_train_t;

    // 2-bit saturating counter, upper bit is the prediction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_t;

    // Pattern table index, history XOR {PC[8:4], slot}
    function automatic lpt_index_t lpt_hash(lh_t lh, pc_t pc, instr_sel_t slot);
        return lh ^ {pc[8:4], slot};
    endfunction

endpackage

//--- lht/lht_index_hash.sv
// Set index fold for the local history table
// PC block bits folded twice, then mixed with the ASID

module lht_index_hash (
    input  lbp_pkg::pc_t       pc,
    input  lbp_pkg::asid_t     asid,
    output lbp_pkg::lht_index_t index
);

    import lbp_pkg::*;

    // --------------------------------------------------
    // Field positions
    // Bits below 4 select the byte within the 16-byte block
    localparam int LO_BASE = 4;
    localparam int HI_BASE = LO_BASE + LHT_INDEX_WIDTH;

    lht_index_t pc_lo;
    lht_index_t pc_hi;
    lht_index_t asid_lo;

    // PC[9:4]
    assign pc_lo   = pc[LO_BASE +: LHT_INDEX_WIDTH];
    // PC[15:10]
    assign pc_hi   = pc[HI_BASE +: LHT_INDEX_WIDTH];
    // Low ASID bits only
    assign asid_lo = asid[LHT_INDEX_WIDTH-1:0];

    // --------------------------------------------------
    // Fold
    assign index = pc_lo ^ pc_hi ^ asid_lo;

endmodule

//--- lht/lht_bram.sv
// History RAM, one read port and one write port
// Registered read with enable, per-slot write enables

module lht_bram #(
    parameter int SETS = lbp_pkg::LHT_SETS
) (
    input  logic                                       CLK,
    input  logic                                       arst_n,

    // Read port
    input  logic                                       ren,
    input  lbp_pkg::lht_index_t                        rindex,
    output lbp_pkg::lh_block_t                         rdata,

    // Write port, one enable per instruction slot
    input  logic [lbp_pkg::LHT_ENTRIES_PER_BLOCK-1:0]  wen_byte,
    input  lbp_pkg::lht_index_t                        windex,
    input  lbp_pkg::lh_block_t                         wdata
);

    import lbp_pkg::*;

    // Address bits actually used for this depth
    localparam int ADDR_W = $clog2(SETS);

    lh_block_t mem [SETS];

    logic [ADDR_W-1:0] raddr;
    logic [ADDR_W-1:0] waddr;

    assign raddr = rindex[ADDR_W-1:0];
    assign waddr = windex[ADDR_W-1:0];

    // --------------------------------------------------
    // Write side
    // Only enabled slots are touched
    always_ff @(posedge CLK) begin
        for (int s = 0; s < LHT_ENTRIES_PER_BLOCK; s++) begin
            if (wen_byte[s]) begin
                mem[waddr][s*LH_LENGTH +: LH_LENGTH] <= wdata[s*LH_LENGTH +: LH_LENGTH];
            end
        end
    end

    // --------------------------------------------------
    // Read side
    // Same-edge write to the same set returns old contents
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- lht/lht.sv
// Local history table
// Request and update set hashing, slot byte mask,
// history RAM and the response valid/PC pipeline

module lht #(
    parameter int SETS = lbp_pkg::LHT_SETS
) (
    input  logic                 CLK,
    input  logic                 arst_n,

    // Lookup request
    input  lbp_pkg::fetch_req_t  fetch_req,

    // History write from the resolve stage
    input  lbp_pkg::lh_update_t  lh_update,

    // Response, one cycle after the request
    output lbp_pkg::lh_block_t   lh_by_instr_resp,
    output logic                 resp_valid,
    output lbp_pkg::pc_t         resp_pc
);

    import lbp_pkg::*;

    // --------------------------------------------------
    // Signals
    lht_index_t  req_index;
    lht_index_t  upd_index;
    instr_sel_t  upd_slot;
    logic [LHT_ENTRIES_PER_BLOCK-1:0] upd_wen;
    lh_block_t   upd_wdata;

    // --------------------------------------------------
    // Request side
    lht_index_hash u_req_hash (
        .pc    (fetch_req.pc),
        .asid  (fetch_req.asid),
        .index (req_index)
    );

    // --------------------------------------------------
    // Update side
    // Hashed with the update's own ASID
    lht_index_hash u_upd_hash (
        .pc    (lh_update.pc),
        .asid  (lh_update.asid),
        .index (upd_index)
    );

    // Slot of the branch within its block, PC[3:1]
    assign upd_slot = lh_update.pc[LOG_LHT_ENTRIES_PER_BLOCK:1];

    // One-hot slot enable
    always_comb begin
        upd_wen           = '0;
        upd_wen[upd_slot] = lh_update.valid;
    end

    // Same history in every slot, mask picks the one
    assign upd_wdata = {LHT_ENTRIES_PER_BLOCK{lh_update.new_lh}};

    // --------------------------------------------------
    // History RAM
    lht_bram #(
        .SETS (SETS)
    ) u_bram (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .ren      (fetch_req.valid),
        .rindex   (req_index),
        .rdata    (lh_by_instr_resp),
        .wen_byte (upd_wen),
        .windex   (upd_index),
        .wdata    (upd_wdata)
    );

    // --------------------------------------------------
    // Response pipeline, matches RAM read latency
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= fetch_req.valid;
        end
    end

    // PC follows the request, no reset needed
    always_ff @(posedge CLK) begin
        if (fetch_req.valid) begin
            resp_pc <= fetch_req.pc;
        end
    end

endmodule

//--- hdl/lbp_resolve.sv
// Resolve stage
// Builds the shifted history update and the counter
// training request, both registered for one cycle

module lbp_resolve (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  lbp_pkg::resolve_t    resolve,
    output lbp_pkg::lh_update_t  lh_update,
    output lbp_pkg::lpt_train_t  lpt_train
);

    import lbp_pkg::*;

    // --------------------------------------------------
    // Next-state values
    lh_t        new_lh_d;
    instr_sel_t slot_d;
    lpt_index_t train_index_d;

    // Outcome shifts in at bit 0
    assign new_lh_d      = {resolve.old_lh[LH_LENGTH-2:0], resolve.taken};
    assign slot_d        = resolve.pc[LOG_LHT_ENTRIES_PER_BLOCK:1];
    // Trains the counter the branch was predicted with
    assign train_index_d = lpt_hash(resolve.old_lh, resolve.pc, slot_d);

    // --------------------------------------------------
    // Registers
    logic       valid_q;
    pc_t        pc_q;
    asid_t      asid_q;
    lh_t        new_lh_q;
    lpt_index_t train_index_q;
    logic       taken_q;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resolve.valid;
        end
    end

    // Payload loads on strobe only
    always_ff @(posedge CLK) begin
        if (resolve.valid) begin
            pc_q          <= resolve.pc;
            asid_q        <= resolve.asid;
            new_lh_q      <= new_lh_d;
            train_index_q <= train_index_d;
            taken_q       <= resolve.taken;
        end
    end

    // --------------------------------------------------
    // Outputs
    assign lh_update = '{valid: valid_q, pc: pc_q, asid: asid_q, new_lh: new_lh_q};
    assign lpt_train = '{valid: valid_q, index: train_index_q, taken: taken_q};

endmodule

//--- hdl/lpt.sv
// Local pattern table
// 2-bit saturating counters, eight lookups per response
// with registered predictions, one training per cycle

module lpt #(
    parameter int LPT_SIZE = lbp_pkg::LPT_ENTRIES
) (
    input  logic                 CLK,
    input  logic                 arst_n,

    // Histories from the table response
    input  logic                 resp_valid,
    input  lbp_pkg::pc_t         resp_pc,
    input  lbp_pkg::lh_block_t   lh_by_instr,

    // Training from the resolve stage
    input  lbp_pkg::lpt_train_t  lpt_train,

    // Predictions, one cycle after resp_valid
    output lbp_pkg::pred_block_t pred_by_instr,
    output logic                 pred_valid
);

    import lbp_pkg::*;

    localparam int ADDR_W = $clog2(LPT_SIZE);

    // --------------------------------------------------
    // Counter update rule
    // Saturates at both ends
    function automatic ctr_t ctr_next(ctr_t c, logic taken);
        ctr_t n;
        n = c;
        if (taken) begin
            if (c != strong_t) begin
                n = ctr_t'(c + 2'd1);
            end
        end else begin
            if (c != strong_nt) begin
                n = ctr_t'(c - 2'd1);
            end
        end
        return n;
    endfunction

    // --------------------------------------------------
    // Signals
    ctr_t        ctrs [LPT_SIZE];
    lpt_index_t  look_index [LHT_ENTRIES_PER_BLOCK];
    pred_block_t pred_d;
    logic [ADDR_W-1:0] train_addr;

    // --------------------------------------------------
    // Lookup, one index per slot
    always_comb begin
        for (int i = 0; i < LHT_ENTRIES_PER_BLOCK; i++) begin
            look_index[i] = lpt_hash(lh_by_instr[i*LH_LENGTH +: LH_LENGTH], resp_pc,
                                     instr_sel_t'(i));
            // Upper counter bit
            pred_d[i]     = ctrs[look_index[i][ADDR_W-1:0]][1];
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= resp_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (resp_valid) begin
            pred_by_instr <= pred_d;
        end
    end

    // --------------------------------------------------
    // Training
    assign train_addr = lpt_train.index[ADDR_W-1:0];

    // All counters start weakly not-taken
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < LPT_SIZE; k++) begin
                ctrs[k] <= weak_nt;
            end
        end else if (lpt_train.valid) begin
            ctrs[train_addr] <= ctr_next(ctrs[train_addr], lpt_train.taken);
        end
    end

endmodule

//--- hdl/lbp_top.sv
// Local-history branch predictor top level
// Resolve stage, history table and pattern table

module lbp_top #(
    parameter int SETS     = lbp_pkg::LHT_SETS,
    parameter int LPT_SIZE = lbp_pkg::LPT_ENTRIES
) (
    input  logic                  CLK,
    input  logic                  arst_n,

    // Lookup strobe
    input  lbp_pkg::fetch_req_t   fetch_req,

    // Resolved branch strobe
    input  lbp_pkg::resolve_t     resolve,

    // Histories, one cycle after fetch_req
    output lbp_pkg::lh_block_t    lh_by_instr_resp,

    // Predictions, two cycles after fetch_req
    output lbp_pkg::pred_block_t  pred_by_instr,
    output logic                  pred_valid
);

    import lbp_pkg::*;

    // --------------------------------------------------
    // Internal wires
    lh_update_t lh_update;
    lpt_train_t lpt_train;
    logic       resp_valid;
    pc_t        resp_pc;

    // --------------------------------------------------
    // Resolve stage
    lbp_resolve u_resolve (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .resolve   (resolve),
        .lh_update (lh_update),
        .lpt_train (lpt_train)
    );

    // --------------------------------------------------
    // History table
    lht #(
        .SETS (SETS)
    ) u_lht (
        .CLK              (CLK),
        .arst_n           (arst_n),
        .fetch_req        (fetch_req),
        .lh_update        (lh_update),
        .lh_by_instr_resp (lh_by_instr_resp),
        .resp_valid       (resp_valid),
        .resp_pc          (resp_pc)
    );

    // --------------------------------------------------
    // Pattern table
    // Fed straight from the table response
    lpt #(
        .LPT_SIZE (LPT_SIZE)
    ) u_lpt (
        .CLK           (CLK),
        .arst_n        (arst_n),
        .resp_valid    (resp_valid),
        .resp_pc       (resp_pc),
        .lh_by_instr   (lh_by_instr_resp),
        .lpt_train     (lpt_train),
        .pred_by_instr (pred_by_instr),
        .pred_valid    (pred_valid)
    );

endmodule

//--- verification/tb_lbp_top.sv
// Testbench for the local-history branch predictor
// Record replay from the stimulus file, expected-value queues,
// history and prediction compare tasks, watchdog

module tb_lbp_top;

    timeunit 1ns;
    timeprecision 100ps;

    import lbp_pkg::*;

    // One line of the stimulus file
    typedef struct packed {
        logic [7:0]  kind;
        pc_t         pc;
        asid_t       asid;
        logic        taken;
        lh_t         old_lh;
        lh_block_t   exp_lh;
        pred_block_t exp_pred;
    } record_t;

    // --------------------------------------------------
    // DUT signals
    logic        CLK;
    logic        arst_n;
    fetch_req_t  fetch_req;
    resolve_t    resolve;
    lh_block_t   lh_by_instr_resp;
    pred_block_t pred_by_instr;
    logic        pred_valid;

    // Records, expected values and their due cycles
    record_t     recs[$];
    lh_block_t   exp_lh_q[$];
    pred_block_t exp_pred_q[$];
    int          lh_due_q[$];
    int          pred_due_q[$];
    int          cyc = 0;
    int          n_rec = 0;
    logic        loaded = 1'b0;
    int          check_count = 0;
    int          mismatch_count = 0;
    int          other_count = 0;
    lh_block_t   exp_lh_v;
    pred_block_t exp_pred_v;

    lbp_top #(
        .SETS     (LHT_SETS),
        .LPT_SIZE (LPT_ENTRIES)
    ) u_lbp_top (
        .CLK              (CLK),
        .arst_n           (arst_n),
        .fetch_req        (fetch_req),
        .resolve          (resolve),
        .lh_by_instr_resp (lh_by_instr_resp),
        .pred_by_instr    (pred_by_instr),
        .pred_valid       (pred_valid)
    );

    // 20 ns clock
    always #10 CLK = ~CLK;

    // Edge count, read by driver and monitor
    always @(posedge CLK) cyc <= cyc + 1;

    // --------------------------------------------------
    // Compare tasks
    task automatic check_lh_block(input lh_block_t exp, input lh_block_t act);
        check_count++;
        if (act !== exp) begin
            $display("mismatch lh_by_instr_resp expected %h actual %h at %0t", exp, act, $time);
            mismatch_count++;
        end
    endtask

    task automatic check_pred_block(input pred_block_t exp, input pred_block_t act);
        check_count++;
        if (act !== exp) begin
            $display("mismatch pred_by_instr expected %h actual %h at %0t", exp, act, $time);
            mismatch_count++;
        end
    endtask

    // --------------------------------------------------
    // Stimulus file
    // Lines starting with # are column notes
    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        pc_t         pc_v;
        asid_t       asid_v;
        logic        taken_v;
        lh_t         old_v;
        lh_block_t   lh_v;
        pred_block_t pred_v;
        record_t     r;
        fd = $fopen("verification/lbp_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file verification/lbp_input.txt");
            other_count++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %h %h",
                                kind, pc_v, asid_v, taken_v, old_v, lh_v, pred_v);
                    if (n != 7 || (kind != "R" && kind != "F" && kind != "I")) begin
                        $display("malformed stimulus line skipped: %s", line);
                        other_count++;
                    end else begin
                        r.kind     = kind;
                        r.pc       = pc_v;
                        r.asid     = asid_v;
                        r.taken    = taken_v;
                        r.old_lh   = old_v;
                        r.exp_lh   = lh_v;
                        r.exp_pred = pred_v;
                        recs.push_back(r);
                    end
                end
            end
            $fclose(fd);
        end
        n_rec = recs.size();
        if (n_rec == 0) begin
            $display("stimulus file holds no records");
            other_count++;
        end
    endtask

    // --------------------------------------------------
    // Driving
    task automatic drive_idle();
        fetch_req.valid = 1'b0;
        resolve.valid   = 1'b0;
    endtask

    // Strobe lands on the next edge, histories visible after it,
    // predictions one edge later
    task automatic apply_record(input record_t r);
        drive_idle();
        if (r.kind == "R") begin
            resolve.valid  = 1'b1;
            resolve.pc     = r.pc;
            resolve.asid   = r.asid;
            resolve.taken  = r.taken;
            resolve.old_lh = r.old_lh;
        end else if (r.kind == "F") begin
            fetch_req.valid = 1'b1;
            fetch_req.pc    = r.pc;
            fetch_req.asid  = r.asid;
            exp_lh_q.push_back(r.exp_lh);
            lh_due_q.push_back(cyc + 1);
            exp_pred_q.push_back(r.exp_pred);
            pred_due_q.push_back(cyc + 2);
        end
    endtask

    // --------------------------------------------------
    // Monitor, outputs sampled mid-cycle
    always @(negedge CLK) begin
        if (!arst_n && pred_valid !== 1'b0) begin
            $display("pred_valid not low during reset at %0t", $time);
            other_count++;
        end
        if (lh_due_q.size() > 0 && lh_due_q[0] == cyc) begin
            exp_lh_v = exp_lh_q.pop_front();
            lh_due_q.delete(0);
            check_lh_block(exp_lh_v, lh_by_instr_resp);
        end
        if (pred_valid === 1'b1) begin
            if (pred_due_q.size() == 0 || pred_due_q[0] != cyc) begin
                $display("pred_valid high with no lookup due at %0t", $time);
                other_count++;
            end else begin
                exp_pred_v = exp_pred_q.pop_front();
                pred_due_q.delete(0);
                check_pred_block(exp_pred_v, pred_by_instr);
            end
        end else if (pred_due_q.size() > 0 && pred_due_q[0] <= cyc) begin
            $display("pred_valid missing for a lookup due at %0t", $time);
            other_count++;
            exp_pred_q.delete(0);
            pred_due_q.delete(0);
        end
    end

    // --------------------------------------------------
    // Main sequence
    initial begin
        CLK       = 1'b0;
        arst_n    = 1'b0;
        fetch_req = '0;
        resolve   = '0;
        load_records();
        loaded = 1'b1;
        repeat (2) @(posedge CLK);
        #1;
        arst_n = 1'b1;
        foreach (recs[i]) begin
            @(posedge CLK);
            #1;
            apply_record(recs[i]);
        end
        @(posedge CLK);
        #1;
        drive_idle();
        // Drain lookups still in flight
        while (lh_due_q.size() > 0 || pred_due_q.size() > 0) begin
            @(posedge CLK);
        end
        repeat (4) @(posedge CLK);
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, one clock period per record plus margin
    initial begin
        wait (loaded);
        #(n_rec * 20 + 1000);
        $display("watchdog expired, run did not finish after %0d records", n_rec);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- lbp_top.f
common/lbp_pkg.sv
lht/lht_index_hash.sv
lht/lht_bram.sv
lht/lht.sv
hdl/lbp_resolve.sv
hdl/lpt.sv
hdl/lbp_top.sv
verification/tb_lbp_top.sv

//--- verification/lbp_input.txt
# kind pc asid taken old_lh exp_lh exp_pred, all hex; kind R=resolve F=fetch I=idle
# exp_lh has slot 7 in the top byte; exp_lh and exp_pred are checked on F lines only
# set 16 init, asid 0, each slot its own history, not-taken
R 00000100 000 0 00 0000000000000000 00
R 00000102 000 0 01 0000000000000000 00
R 00000104 000 0 02 0000000000000000 00
R 00000106 000 0 03 0000000000000000 00
R 00000108 000 0 04 0000000000000000 00
R 0000010a 000 0 05 0000000000000000 00
R 0000010c 000 0 06 0000000000000000 00
R 0000010e 000 0 07 0000000000000000 00
# set 17 init, same block under asid 1, taken
R 00000100 001 1 10 0000000000000000 00
R 00000102 001 1 11 0000000000000000 00
R 00000104 001 1 12 0000000000000000 00
R 00000106 001 1 13 0000000000000000 00
R 00000108 001 1 14 0000000000000000 00
R 0000010a 001 1 15 0000000000000000 00
R 0000010c 001 1 16 0000000000000000 00
R 0000010e 001 1 17 0000000000000000 00
I 00000000 000 0 00 0000000000000000 00
F 00000100 000 0 00 0e0c0a0806040200 00
F 00000100 001 0 00 2f2d2b2927252321 00
# history shift on slot 3, single write to slot 5
R 00000106 000 1 06 0000000000000000 00
R 00000106 000 1 0d 0000000000000000 00
R 00000106 000 0 1b 0000000000000000 00
R 0000010a 000 1 0a 0000000000000000 00
I 00000000 000 0 00 0000000000000000 00
F 00000100 000 0 00 0e0c150836040200 20
# counter training on slot 0 of set 17, loop history ff
R 00000100 001 1 ff 0000000000000000 00
R 00000100 001 1 ff 0000000000000000 00
R 00000100 001 1 ff 0000000000000000 00
R 00000100 001 1 ff 0000000000000000 00
I 00000000 000 0 00 0000000000000000 00
F 00000100 001 0 00 2f2d2b29272523ff 01
R 00000100 001 0 ff 0000000000000000 00
R 00000100 001 1 7f 0000000000000000 00
F 00000100 001 0 00 2f2d2b29272523fe 00
F 00000100 001 0 00 2f2d2b29272523ff 01
R 00000100 001 0 ff 0000000000000000 00
R 00000100 001 1 7f 0000000000000000 00
I 00000000 000 0 00 0000000000000000 00
F 00000100 001 0 00 2f2d2b29272523ff 00
